//--- Bender.yml
package:
  name: issue_stage

sources:
  - src/issue_pkg.sv
  - src/tag_ready_table.sv
  - src/rs_station.sv
  - src/fu_pipe.sv
  - src/cdb_arbiter.sv
  - src/issue_top.sv
  - target: test
    files:
      - tb/tb_issue_top.sv

//--- sim.f
src/issue_pkg.sv
src/tag_ready_table.sv
src/rs_station.sv
src/fu_pipe.sv
src/cdb_arbiter.sv
src/issue_top.sv
tb/tb_issue_top.sv

//--- src/cdb_arbiter.sv
`timescale 1ns/10ps

module cdb_arbiter #(
  parameter int NUM_ROB  = 16,
  parameter int NUM_TAGS = 32
) (
  input  logic                                               clock,
  input  logic                                               reset,
  input  logic [issue_pkg::NUM_FU-1:0]                       complete_req,
  input  logic [issue_pkg::NUM_FU-1:0][$clog2(NUM_TAGS)-1:0] complete_tag,
  input  logic [issue_pkg::NUM_FU-1:0][$clog2(NUM_ROB)-1:0]  complete_rob,
  output logic [issue_pkg::NUM_FU-1:0]                       grant,
  output logic                                               cdb_valid,
  output logic [$clog2(NUM_TAGS)-1:0]                        cdb_tag,
  output logic [$clog2(NUM_ROB)-1:0]                         cdb_rob_idx
);

  import issue_pkg::*;

  localparam int SEL_W = $clog2(NUM_FU);

  logic [SEL_W-1:0] sel;  // Winning unit

  // Lowest index wins, so scan downward and let later hits overwrite
  always_comb begin
    grant = '0;
    sel   = '0;
    for (int i = NUM_FU - 1; i >= 0; i--) begin
      if (complete_req[i]) begin
        sel = SEL_W'(i);
      end
    end
    grant[sel] = |complete_req;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= |complete_req;  // Broadcast next cycle
    end
  end

  always_ff @(posedge clock) begin
    cdb_tag     <= complete_tag[sel];
    cdb_rob_idx <= complete_rob[sel];
  end

  a_grant_onehot: assert property (
    @(posedge clock) disable iff (reset)
    $onehot0(grant)
  ) else $error("cdb_arbiter: grant not one-hot, %b", grant);

  // A unit that loses arbitration keeps requesting until served
  for (genvar i = 0; i < NUM_FU; i++) begin : g_hold_chk
    a_req_held: assert property (
      @(posedge clock) disable iff (reset)
      (complete_req[i] && !grant[i]) |=> complete_req[i]
    ) else $error("cdb_arbiter: unit %0d dropped an ungranted request", i);
  end

endmodule

//--- src/fu_pipe.sv
`timescale 1ns/10ps

module fu_pipe #(
  parameter int NUM_ROB  = 16,
  parameter int NUM_TAGS = 32,
  parameter int LATENCY  = 1
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        issue_valid,
  input  logic [$clog2(NUM_TAGS)-1:0] issue_tag,
  input  logic [$clog2(NUM_ROB)-1:0]  issue_rob_idx,
  input  logic                        grant,
  output logic                        fu_free,
  output logic                        complete_req,
  output logic [$clog2(NUM_TAGS)-1:0] complete_tag,
  output logic [$clog2(NUM_ROB)-1:0]  complete_rob
);

  localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

  logic             busy;   // Holds an operation
  logic [CNT_W-1:0] count;  // Cycles left before completion

  assign complete_req = busy && (count == '0);
  // Free again on the cycle the held result goes out
  assign fu_free      = !busy || (complete_req && grant);

  always_ff @(posedge clock) begin
    if (reset) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (issue_valid) begin
      busy  <= 1'b1;
      count <= CNT_W'(LATENCY - 1);  // Req after LATENCY cycles
    end else if (busy && count != '0) begin
      count <= count - 1'b1;
    end else if (complete_req && grant) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (issue_valid) begin
      complete_tag <= issue_tag;
      complete_rob <= issue_rob_idx;
    end
  end

  // The station must see back-pressure while a result waits for the CDB
  a_no_issue_when_full: assert property (
    @(posedge clock) disable iff (reset)
    issue_valid |-> (!busy || (complete_req && grant))
  ) else $error("fu_pipe: issue into occupied pipe, tag %0d", issue_tag);

endmodule

//--- src/issue_pkg.sv
package issue_pkg;

  // Functional-unit kinds. The code of each kind is also the index of its
  // reservation-station entry and of its pipe.
  typedef enum logic [1:0] {
    FU_ALU    = 2'd0,  // Integer ops
    FU_MUL    = 2'd1,  // Multiplier
    FU_LOAD   = 2'd2,  // Load unit
    FU_BRANCH = 2'd3   // Branch resolve
  } fu_kind_e;

  // One unit per kind
  localparam int NUM_FU = 4;

endpackage

//--- src/issue_top.sv
`timescale 1ns/10ps

module issue_top #(
  parameter int NUM_ROB      = 16,
  parameter int NUM_TAGS     = 32,
  parameter int MUL_LATENCY  = 3,
  parameter int LOAD_LATENCY = 2
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        dispatch_req,
  input  issue_pkg::fu_kind_e         dispatch_kind,
  input  logic [$clog2(NUM_ROB)-1:0]  dispatch_rob_idx,
  input  logic [$clog2(NUM_TAGS)-1:0] dispatch_dest_tag,
  input  logic [$clog2(NUM_TAGS)-1:0] dispatch_src1_tag,
  input  logic [$clog2(NUM_TAGS)-1:0] dispatch_src2_tag,
  output logic                        dispatch_ack,
  input  logic                        rollback_en,
  input  logic [$clog2(NUM_ROB)-1:0]  rollback_idx,
  input  logic [$clog2(NUM_ROB)-1:0]  rollback_count,
  output logic                        cdb_valid,
  output logic [$clog2(NUM_TAGS)-1:0] cdb_tag,
  output logic [$clog2(NUM_ROB)-1:0]  cdb_rob_idx
);

  import issue_pkg::*;

  localparam int ROB_W = $clog2(NUM_ROB);
  localparam int TAG_W = $clog2(NUM_TAGS);

  logic                         src1_ready;
  logic                         src2_ready;
  logic                         alloc_en;
  logic [NUM_FU-1:0]            issue_valid;
  logic [NUM_FU-1:0][TAG_W-1:0] issue_tag;
  logic [NUM_FU-1:0][ROB_W-1:0] issue_rob_idx;
  logic [NUM_FU-1:0]            fu_free;
  logic [NUM_FU-1:0]            complete_req;
  logic [NUM_FU-1:0][TAG_W-1:0] complete_tag;
  logic [NUM_FU-1:0][ROB_W-1:0] complete_rob;
  logic [NUM_FU-1:0]            grant;

  tag_ready_table #(.NUM_TAGS(NUM_TAGS)) u_table (
    .clock      (clock),
    .reset      (reset),
    .alloc_en   (alloc_en),
    .alloc_tag  (dispatch_dest_tag),
    .cdb_valid  (cdb_valid),
    .cdb_tag    (cdb_tag),
    .src1_tag   (dispatch_src1_tag),
    .src2_tag   (dispatch_src2_tag),
    .src1_ready (src1_ready),
    .src2_ready (src2_ready)
  );

  rs_station #(.NUM_ROB(NUM_ROB), .NUM_TAGS(NUM_TAGS)) u_rs (
    .clock             (clock),
    .reset             (reset),
    .dispatch_req      (dispatch_req),
    .dispatch_kind     (dispatch_kind),
    .dispatch_rob_idx  (dispatch_rob_idx),
    .dispatch_dest_tag (dispatch_dest_tag),
    .dispatch_src1_tag (dispatch_src1_tag),
    .dispatch_src2_tag (dispatch_src2_tag),
    .src1_ready        (src1_ready),
    .src2_ready        (src2_ready),
    .cdb_valid         (cdb_valid),
    .cdb_tag           (cdb_tag),
    .rollback_en       (rollback_en),
    .rollback_idx      (rollback_idx),
    .rollback_count    (rollback_count),
    .fu_free           (fu_free),
    .dispatch_ack      (dispatch_ack),
    .alloc_en          (alloc_en),
    .issue_valid       (issue_valid),
    .issue_tag         (issue_tag),
    .issue_rob_idx     (issue_rob_idx)
  );

  // Pipe i serves the kind whose code is i
  for (genvar i = 0; i < NUM_FU; i++) begin : g_fu
    localparam int LAT = (i == int'(FU_MUL))  ? MUL_LATENCY  :
                         (i == int'(FU_LOAD)) ? LOAD_LATENCY : 1;

    fu_pipe #(.NUM_ROB(NUM_ROB), .NUM_TAGS(NUM_TAGS), .LATENCY(LAT)) u_pipe (
      .clock         (clock),
      .reset         (reset),
      .issue_valid   (issue_valid[i]),
      .issue_tag     (issue_tag[i]),
      .issue_rob_idx (issue_rob_idx[i]),
      .grant         (grant[i]),
      .fu_free       (fu_free[i]),
      .complete_req  (complete_req[i]),
      .complete_tag  (complete_tag[i]),
      .complete_rob  (complete_rob[i])
    );
  end

  cdb_arbiter #(.NUM_ROB(NUM_ROB), .NUM_TAGS(NUM_TAGS)) u_arb (
    .clock        (clock),
    .reset        (reset),
    .complete_req (complete_req),
    .complete_tag (complete_tag),
    .complete_rob (complete_rob),
    .grant        (grant),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .cdb_rob_idx  (cdb_rob_idx)
  );

endmodule

//--- src/rs_station.sv
`timescale 1ns/10ps

module rs_station #(
  parameter int NUM_ROB  = 16,
  parameter int NUM_TAGS = 32
) (
  input  logic                                               clock,
  input  logic                                               reset,
  input  logic                                               dispatch_req,
  input  issue_pkg::fu_kind_e                                dispatch_kind,
  input  logic [$clog2(NUM_ROB)-1:0]                         dispatch_rob_idx,
  input  logic [$clog2(NUM_TAGS)-1:0]                        dispatch_dest_tag,
  input  logic [$clog2(NUM_TAGS)-1:0]                        dispatch_src1_tag,
  input  logic [$clog2(NUM_TAGS)-1:0]                        dispatch_src2_tag,
  input  logic                                               src1_ready,
  input  logic                                               src2_ready,
  input  logic                                               cdb_valid,
  input  logic [$clog2(NUM_TAGS)-1:0]                        cdb_tag,
  input  logic                                               rollback_en,
  input  logic [$clog2(NUM_ROB)-1:0]                         rollback_idx,
  input  logic [$clog2(NUM_ROB)-1:0]                         rollback_count,
  input  logic [issue_pkg::NUM_FU-1:0]                       fu_free,
  output logic                                               dispatch_ack,
  output logic                                               alloc_en,
  output logic [issue_pkg::NUM_FU-1:0]                       issue_valid,
  output logic [issue_pkg::NUM_FU-1:0][$clog2(NUM_TAGS)-1:0] issue_tag,
  output logic [issue_pkg::NUM_FU-1:0][$clog2(NUM_ROB)-1:0]  issue_rob_idx
);

  import issue_pkg::*;

  localparam int ROB_W = $clog2(NUM_ROB);
  localparam int TAG_W = $clog2(NUM_TAGS);

  // Entry storage
  logic [NUM_FU-1:0]            busy;
  logic [NUM_FU-1:0][ROB_W-1:0] rob_idx;
  logic [NUM_FU-1:0][TAG_W-1:0] dest_tag;
  logic [NUM_FU-1:0][TAG_W-1:0] src1_tag;
  logic [NUM_FU-1:0][TAG_W-1:0] src2_tag;
  logic [NUM_FU-1:0]            src1_rdy;
  logic [NUM_FU-1:0]            src2_rdy;

  // Per-entry decisions for this cycle
  logic [NUM_FU-1:0]            src1_ok;
  logic [NUM_FU-1:0]            src2_ok;
  logic [NUM_FU-1:0][ROB_W-1:0] rob_dist;
  logic [NUM_FU-1:0]            squash;
  logic [NUM_FU-1:0]            issue_go;
  logic [NUM_FU-1:0]            leaving;
  logic                         entry_open;
  logic                         dispatch_we;

  always_comb begin
    for (int i = 0; i < NUM_FU; i++) begin
      src1_ok[i]  = src1_rdy[i] || (cdb_valid && cdb_tag == src1_tag[i]);  // CDB wakeup
      src2_ok[i]  = src2_rdy[i] || (cdb_valid && cdb_tag == src2_tag[i]);
      rob_dist[i] = rob_idx[i] - rollback_idx;  // Circular distance
      squash[i]   = rollback_en && busy[i] && (rob_dist[i] <= rollback_count);
      issue_go[i] = busy[i] && src1_ok[i] && src2_ok[i] && fu_free[i] && !squash[i];
      leaving[i]  = issue_go[i] || squash[i];
    end
  end

  // Kind's entry is empty or empties on this edge
  assign entry_open  = !busy[dispatch_kind] || leaving[dispatch_kind];
  assign dispatch_we = dispatch_req && !dispatch_ack && entry_open;
  assign alloc_en    = dispatch_we;

  assign issue_valid   = issue_go;
  assign issue_tag     = dest_tag;
  assign issue_rob_idx = rob_idx;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy         <= '0;
      dispatch_ack <= 1'b0;
    end else begin
      // Held while req stays up, drops the cycle after req falls
      dispatch_ack <= dispatch_req && (dispatch_ack || entry_open);
      for (int i = 0; i < NUM_FU; i++) begin
        if (leaving[i]) begin
          busy[i] <= 1'b0;  // Issued or squashed
        end
      end
      if (dispatch_we) begin
        busy[dispatch_kind] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    src1_rdy <= src1_ok;  // Keep wakeups
    src2_rdy <= src2_ok;
    if (dispatch_we) begin
      rob_idx[dispatch_kind]  <= dispatch_rob_idx;
      dest_tag[dispatch_kind] <= dispatch_dest_tag;
      src1_tag[dispatch_kind] <= dispatch_src1_tag;
      src2_tag[dispatch_kind] <= dispatch_src2_tag;
      src1_rdy[dispatch_kind] <= src1_ready;  // Table lookup with bypass
      src2_rdy[dispatch_kind] <= src2_ready;
    end
  end

  a_ack_needs_req: assert property (
    @(posedge clock) disable iff (reset)
    $rose(dispatch_ack) |-> $past(dispatch_req)
  ) else $error("rs_station: dispatch_ack rose without dispatch_req");

  // A waiting instruction keeps its fields until it leaves
  for (genvar i = 0; i < NUM_FU; i++) begin : g_hold_chk
    a_entry_kept: assert property (
      @(posedge clock) disable iff (reset)
      (busy[i] && !leaving[i]) |=> (busy[i] && rob_idx[i] == $past(rob_idx[i])
                                    && dest_tag[i] == $past(dest_tag[i]))
    ) else $error("rs_station: busy entry %0d overwritten", i);
  end

endmodule

//--- src/tag_ready_table.sv
`timescale 1ns/10ps

module tag_ready_table #(
  parameter int NUM_TAGS = 32
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        alloc_en,
  input  logic [$clog2(NUM_TAGS)-1:0] alloc_tag,
  input  logic                        cdb_valid,
  input  logic [$clog2(NUM_TAGS)-1:0] cdb_tag,
  input  logic [$clog2(NUM_TAGS)-1:0] src1_tag,
  input  logic [$clog2(NUM_TAGS)-1:0] src2_tag,
  output logic                        src1_ready,
  output logic                        src2_ready
);

  logic [NUM_TAGS-1:0] ready;  // One bit per physical tag

  // A completion and a new allocation of the same tag in one cycle means
  // the new producer owns it, so the clear is applied last
  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= '1;  // Nothing in flight
    end else begin
      if (cdb_valid) begin
        ready[cdb_tag] <= 1'b1;  // Producer done
      end
      if (alloc_en) begin
        ready[alloc_tag] <= 1'b0;  // New producer
      end
    end
  end

  // Same-cycle CDB bypass
  assign src1_ready = ready[src1_tag] || (cdb_valid && cdb_tag == src1_tag);
  assign src2_ready = ready[src2_tag] || (cdb_valid && cdb_tag == src2_tag);

  // A destination tag handed out at dispatch must not still have a live producer
  a_alloc_tag_free: assert property (
    @(posedge clock) disable iff (reset)
    alloc_en |-> (ready[alloc_tag] || (cdb_valid && cdb_tag == alloc_tag))
  ) else $error("tag_ready_table: tag %0d allocated while still pending", alloc_tag);

endmodule

//--- tb/tb_issue_top.sv
`timescale 1ns/10ps

module tb_issue_top;

  import issue_pkg::*;

  localparam int TAG_W   = 5;
  localparam int ROB_W   = 4;
  localparam int T_LIMIT = 200;  // Cycles allowed per wait

  logic             clock;
  logic             reset;
  logic             dispatch_req;
  fu_kind_e         dispatch_kind;
  logic [ROB_W-1:0] dispatch_rob_idx;
  logic [TAG_W-1:0] dispatch_dest_tag;
  logic [TAG_W-1:0] dispatch_src1_tag;
  logic [TAG_W-1:0] dispatch_src2_tag;
  logic             dispatch_ack;
  logic             rollback_en;
  logic [ROB_W-1:0] rollback_idx;
  logic [ROB_W-1:0] rollback_count;
  logic             cdb_valid;
  logic [TAG_W-1:0] cdb_tag;
  logic [ROB_W-1:0] cdb_rob_idx;

  // Scoreboard, indexed by destination tag
  logic [31:0]      tag_live;       // Dispatched, not yet broadcast
  logic [31:0]      tag_dead;       // Squashed, must stay off the CDB
  logic [ROB_W-1:0] exp_rob [32];
  logic [TAG_W-1:0] src1_of [32];
  logic [TAG_W-1:0] src2_of [32];
  int               need1 [32];     // Source broadcasts owed before this one
  int               need2 [32];
  int               cdb_count [32];
  logic [TAG_W-1:0] recent [4];     // Last destinations, used as sources
  logic [TAG_W-1:0] last_tag;
  logic [ROB_W-1:0] rob_next;
  logic             expect_no_ack;  // Kind's entry known to be occupied

  issue_top dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic report_mismatch(string name, int expected, int actual);
    $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at the first failing check");
  endtask

  task automatic abort_on_timeout(string what);
    $display("Timed out waiting for %s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped after a timeout");
  endtask

  function automatic logic [TAG_W-1:0] next_free_tag();
    for (int k = 0; k < 31; k++) begin
      last_tag = (last_tag == 5'd31) ? 5'd1 : last_tag + 5'd1;  // Tag 0 never allocated
      if (!tag_live[last_tag] && !tag_dead[last_tag]) return last_tag;
    end
    return '0;
  endfunction

  function automatic logic [TAG_W-1:0] pick_source();
    if ($urandom_range(2, 0) == 0) return '0;  // Always ready
    return recent[$urandom_range(3, 0)];
  endfunction

  task automatic raise_dispatch(fu_kind_e kind, logic [TAG_W-1:0] dest,
                                logic [TAG_W-1:0] s1, logic [TAG_W-1:0] s2);
    @(negedge clock);
    need1[dest]    = cdb_count[s1] + int'(tag_live[s1] || tag_dead[s1]);  // Pending or squashed
    need2[dest]    = cdb_count[s2] + int'(tag_live[s2] || tag_dead[s2]);
    src1_of[dest]  = s1;
    src2_of[dest]  = s2;
    exp_rob[dest]  = rob_next;
    tag_live[dest] = 1'b1;
    @(posedge clock);
    dispatch_req      <= 1'b1;
    dispatch_kind     <= kind;
    dispatch_rob_idx  <= rob_next;
    dispatch_dest_tag <= dest;
    dispatch_src1_tag <= s1;
    dispatch_src2_tag <= s2;
    rob_next = rob_next + 1'b1;
  endtask

  // Second half of the four-phase handshake
  task automatic finish_dispatch();
    int waited;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
      if (waited > T_LIMIT) abort_on_timeout("dispatch_ack to rise");
    end while (!dispatch_ack);
    @(posedge clock);
    dispatch_req <= 1'b0;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
      if (waited > T_LIMIT) abort_on_timeout("dispatch_ack to fall");
    end while (dispatch_ack);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (tag_live != '0) begin
      @(negedge clock);
      waited++;
      if (waited > T_LIMIT) abort_on_timeout("dispatched instructions to reach the CDB");
    end
  endtask

  // One-entry window around the victim's ROB index
  task automatic pulse_rollback(logic [TAG_W-1:0] victim);
    @(posedge clock);
    rollback_en      <= 1'b1;
    rollback_idx     <= exp_rob[victim];
    rollback_count   <= '0;
    expect_no_ack    <= 1'b0;  // Entry may refill from here on
    tag_live[victim] = 1'b0;
    tag_dead[victim] = 1'b1;
    @(posedge clock);
    rollback_en <= 1'b0;
  endtask

  always @(posedge clock) begin
    if (!reset && cdb_valid) begin
      tag_live[cdb_tag]  = 1'b0;
      cdb_count[cdb_tag] = cdb_count[cdb_tag] + 1;
    end
  end

  a_reset_quiet: assert property (@(posedge clock)
    $fell(reset) |-> (!dispatch_ack && !cdb_valid) [*3])
    else report_mismatch("reset_quiet", 0, $sampled(dispatch_ack || cdb_valid));
  a_ack_needs_req: assert property (@(posedge clock) disable iff (reset)
    $rose(dispatch_ack) |-> $past(dispatch_req) && dispatch_req)
    else report_mismatch("ack_needs_req", 1, $sampled(dispatch_req));
  a_ack_held: assert property (@(posedge clock) disable iff (reset)
    (dispatch_ack && dispatch_req) |=> dispatch_ack)
    else report_mismatch("ack_held", 1, $sampled(dispatch_ack));
  a_ack_release: assert property (@(posedge clock) disable iff (reset)
    $fell(dispatch_req) |-> dispatch_ack ##1 !dispatch_ack)
    else report_mismatch("ack_release", 0, $sampled(dispatch_ack));
  a_kind_blocked: assert property (@(posedge clock) disable iff (reset)
    expect_no_ack |-> !dispatch_ack)
    else report_mismatch("kind_blocked", 0, $sampled(dispatch_ack));
  a_cdb_once: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> tag_live[cdb_tag])
    else report_mismatch("cdb_once", 1, $sampled(tag_live[cdb_tag]));
  a_cdb_rob: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> cdb_rob_idx == exp_rob[cdb_tag])
    else report_mismatch("cdb_rob", $sampled(exp_rob[cdb_tag]), $sampled(cdb_rob_idx));
  a_cdb_src1: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> cdb_count[src1_of[cdb_tag]] >= need1[cdb_tag])
    else report_mismatch("cdb_src1", $sampled(need1[cdb_tag]),
                         $sampled(cdb_count[src1_of[cdb_tag]]));
  a_cdb_src2: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> cdb_count[src2_of[cdb_tag]] >= need2[cdb_tag])
    else report_mismatch("cdb_src2", $sampled(need2[cdb_tag]),
                         $sampled(cdb_count[src2_of[cdb_tag]]));

  initial begin
    fu_kind_e         kind;
    logic [TAG_W-1:0] dest;
    logic [TAG_W-1:0] tag_a;
    logic [TAG_W-1:0] tag_x;
    void'($urandom(32'hd1d7_b9bc));
    reset             = 1'b1;
    dispatch_req      = 1'b0;
    dispatch_kind     = FU_ALU;
    dispatch_rob_idx  = '0;
    dispatch_dest_tag = '0;
    dispatch_src1_tag = '0;
    dispatch_src2_tag = '0;
    rollback_en       = 1'b0;
    rollback_idx      = '0;
    rollback_count    = '0;
    tag_live          = '0;
    tag_dead          = '0;
    last_tag          = '0;
    rob_next          = '0;
    expect_no_ack     = 1'b0;
    for (int i = 0; i < 32; i++) begin
      cdb_count[i] = 0;
      recent[i % 4] = '0;
    end
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    repeat (4) @(posedge clock);
    for (int n = 0; n < 60; n++) begin
      kind = fu_kind_e'($urandom_range(3, 0));
      dest = next_free_tag();
      raise_dispatch(kind, dest, pick_source(), pick_source());
      finish_dispatch();
      recent[n % 4] = dest;
    end
    wait_drain();
    // A is squashed right after its write, so its tag is never produced
    tag_a = next_free_tag();
    raise_dispatch(FU_ALU, tag_a, '0, '0);
    pulse_rollback(tag_a);
    finish_dispatch();
    tag_x = next_free_tag();
    raise_dispatch(FU_MUL, tag_x, tag_a, '0);  // Waits forever on tag_a
    finish_dispatch();
    raise_dispatch(FU_MUL, next_free_tag(), '0, '0);
    expect_no_ack <= 1'b1;
    repeat (8) @(posedge clock);
    pulse_rollback(tag_x);
    finish_dispatch();
    wait_drain();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
